// File: compile.f
design/conveyor_pkg.sv
design/conveyor_control.sv
design/issue_fsm.sv
design/stall_timer.sv
design/mul_pipe.sv
design/conveyor_core.sv
tests/conveyor_core_tb.sv

// File: design/conveyor_control.sv
`timescale 1ns/100ps
`default_nettype none

module conveyor_control import conveyor_pkg::*; #(
  parameter int CONVEYOR_ADDR_WIDTH = conv_addr_width
) (
  input  wire                            clk,
  input  wire                            reset,
  input  wire instr_u                    instr,
  input  wire                            accept,
  input  wire                            servicing,
  input  wire                            ctx,
  input  wire word_t                     ret_count,
  input  wire word_t                     irq_bus,
  input  wire slot_wr_t                  mul_wr,
  output logic                           halt,
  output slot_t                          operand_a,
  output slot_t                          operand_b,
  output logic [CONVEYOR_ADDR_WIDTH-1:0] dest_addr,
  output word_t                          out_value,
  output fault_t                         out_fault
);

  localparam int CONVEYOR_SIZE = 1 << CONVEYOR_ADDR_WIDTH;

  // one conveyor per context; index 0 is the main program.
  slot_t conv [2][CONVEYOR_SIZE];
  logic [CONVEYOR_ADDR_WIDTH-1:0] heads [2];

  kind_t kind;
  logic [CONVEYOR_ADDR_WIDTH-1:0] head;
  logic [CONVEYOR_ADDR_WIDTH-1:0] addr_a;
  logic [CONVEYOR_ADDR_WIDTH-1:0] addr_b;
  logic [CONVEYOR_ADDR_WIDTH-1:0] main_back1;
  logic [CONVEYOR_ADDR_WIDTH-1:0] main_back2;
  logic take;

  // ==============================
  // operand addressing
  // ==============================

  assign kind = decode(instr);
  assign head = heads[ctx];
  assign addr_a = head + CONVEYOR_ADDR_WIDTH'(instr.off.offset);
  assign addr_b = addr_a + 1'b1;       // second mul operand sits one slot further in.
  assign dest_addr = head - 1'b1;      // new results go just behind the head.
  assign operand_a = conv[ctx][addr_a];
  assign operand_b = conv[ctx][addr_b];

  // interrupt entry always pushes onto the main conveyor.
  assign main_back1 = heads[0] - 1'b1;
  assign main_back2 = heads[0] - 2'd2;

  // An accept while halt is high is the stall timer dropping the instruction.
  assign take = accept && !halt;

  // halt follows the instruction byte on its own; the testbench drives a nop when idle.
  always_comb begin
    case (kind)
      k_cvz:   halt = !operand_a.finished;
      k_mul:   halt = !(operand_a.finished && operand_b.finished);
      default: halt = 1'b0;
    endcase
  end

  // ==============================
  // slot writes
  // ==============================

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int c = 0; c < 2; c++) begin
        for (int s = 0; s < CONVEYOR_SIZE; s++) begin
          conv[c][s] <= '0;  // unfinished, f_none.
        end
      end
      heads[0] <= '0;
      heads[1] <= '0;
    end else begin
      if (mul_wr.en) begin
        conv[mul_wr.ctx][mul_wr.addr] <= mul_wr.data;
      end
      if (servicing) begin
        conv[0][main_back1] <= '{finished: 1'b1, fault: f_none, value: ret_count};
        conv[0][main_back2] <= '{finished: 1'b1, fault: f_none, value: irq_bus};
        heads[0] <= main_back2;
        heads[1] <= '0;  // the handler starts on a fresh head.
      end else if (take && kind == k_psh) begin
        conv[ctx][dest_addr] <= '{finished: 1'b1, fault: f_none,
                                  value: word_t'(instr.imm.value)};
        heads[ctx] <= dest_addr;
      end else if (take && kind == k_mul) begin
        // reserve the result slot; mul_pipe fills it in later.
        conv[ctx][dest_addr] <= '{finished: 1'b0, fault: f_none, value: '0};
        heads[ctx] <= dest_addr;
      end
    end
  end

  // cvz result, captured at acceptance and shown on the next cycle.
  always_ff @(posedge clk) begin
    if (accept && kind == k_cvz) begin
      out_value <= operand_a.value;
      out_fault <= halt ? f_stall : operand_a.fault;
    end
  end

endmodule

`default_nettype wire

// File: design/conveyor_core.sv
`timescale 1ns/100ps
`default_nettype none

module conveyor_core import conveyor_pkg::*; #(
  parameter int CONVEYOR_ADDR_WIDTH = conv_addr_width,
  parameter int MUL_LATENCY = 3,
  parameter int STALL_LIMIT = 12
) (
  input  wire         clk,
  input  wire         reset,
  input  wire instr_u instr,
  input  wire         instr_valid,
  input  wire         irq,
  input  wire word_t  irq_bus,
  output wire         halt,
  output wire         out_valid,
  output wire word_t  out_value,
  output wire fault_t out_fault,
  output wire         int_active,
  output wire         stall
);

  logic accept;
  logic servicing;
  logic ctx;
  logic mul_start;
  word_t ret_count;
  slot_t operand_a;
  slot_t operand_b;
  logic [CONVEYOR_ADDR_WIDTH-1:0] dest_addr;
  slot_wr_t mul_wr;

  // the handler runs on conveyor 1, so the active context is the interrupt flag.
  assign int_active = ctx;

  // ==============================
  // blocks
  // ==============================

  issue_fsm u_issue_fsm (
    .clk         (clk),
    .reset       (reset),
    .instr       (instr),
    .instr_valid (instr_valid),
    .halt        (halt),
    .stall       (stall),
    .irq         (irq),
    .accept      (accept),
    .servicing   (servicing),
    .ctx         (ctx),
    .ret_count   (ret_count),
    .out_valid   (out_valid),
    .mul_start   (mul_start)
  );

  conveyor_control #(
    .CONVEYOR_ADDR_WIDTH (CONVEYOR_ADDR_WIDTH)
  ) u_conveyor_control (
    .clk       (clk),
    .reset     (reset),
    .instr     (instr),
    .accept    (accept),
    .servicing (servicing),
    .ctx       (ctx),
    .ret_count (ret_count),
    .irq_bus   (irq_bus),
    .mul_wr    (mul_wr),
    .halt      (halt),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .dest_addr (dest_addr),
    .out_value (out_value),
    .out_fault (out_fault)
  );

  stall_timer #(
    .STALL_LIMIT (STALL_LIMIT)
  ) u_stall_timer (
    .clk   (clk),
    .reset (reset),
    .halt  (halt),
    .stall (stall)
  );

  mul_pipe #(
    .MUL_LATENCY (MUL_LATENCY)
  ) u_mul_pipe (
    .clk       (clk),
    .reset     (reset),
    .start     (mul_start),
    .ctx       (ctx),
    .dest_addr (dest_addr),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .result    (mul_wr)
  );

endmodule

`default_nettype wire

// File: design/conveyor_pkg.sv
`default_nettype none

package conveyor_pkg;

  // ==============================
  // widths and basic types
  // ==============================

  localparam int word_width = 16;
  localparam int conv_addr_width = 4;

  typedef logic [word_width-1:0] word_t;
  typedef logic [conv_addr_width-1:0] addr_t;

  typedef enum logic [1:0] {
    f_none     = 2'd0,
    f_overflow = 2'd1,  // product did not fit in one word.
    f_stall    = 2'd2   // a cvz waited past the stall limit.
  } fault_t;

  // opcodes are matched on the upper bits of the instruction byte.
  localparam logic [3:0] op_nop = 4'b0000;
  localparam logic [3:0] op_rti = 4'b0001;
  localparam logic [1:0] op_psh = 2'b01;    // tag of the immediate view.
  localparam logic [3:0] op_mul = 4'b1000;
  localparam logic [3:0] op_cvz = 4'b1100;

  // ==============================
  // structs and the instruction
  // ==============================

  typedef struct packed {
    logic   finished;
    fault_t fault;
    word_t  value;
  } slot_t;

  // the same byte reads as op plus offset, or as a psh tag plus immediate.
  typedef union packed {
    struct packed {
      logic [3:0] op;
      logic [3:0] offset;
    } off;
    struct packed {
      logic [1:0] tag;
      logic [5:0] value;
    } imm;
  } instr_u;

  typedef struct packed {
    logic  en;
    logic  ctx;
    addr_t addr;
    slot_t data;
  } slot_wr_t;

  typedef enum logic [2:0] {k_nop, k_rti, k_psh, k_mul, k_cvz} kind_t;

  // the psh tag overlaps the op field, so it is checked first.
  function automatic kind_t decode(instr_u i);
    kind_t k;
    if (i.imm.tag == op_psh) begin
      k = k_psh;
    end else begin
      case (i.off.op)
        op_nop:  k = k_nop;
        op_rti:  k = k_rti;
        op_mul:  k = k_mul;
        op_cvz:  k = k_cvz;
        default: k = k_nop;  // unused patterns behave as nop.
      endcase
    end
    return k;
  endfunction

endpackage

`default_nettype wire

// File: design/issue_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module issue_fsm import conveyor_pkg::*; (
  input  wire         clk,
  input  wire         reset,
  input  wire instr_u instr,
  input  wire         instr_valid,
  input  wire         halt,
  input  wire         stall,
  input  wire         irq,
  output logic        accept,
  output logic        servicing,
  output logic        ctx,
  output word_t       ret_count,
  output logic        out_valid,
  output logic        mul_start
);

  typedef enum logic [1:0] {
    run_main,
    entering,  // one cycle of pushes onto the main conveyor.
    run_int
  } state_t;

  state_t state;
  kind_t kind;

  assign kind = decode(instr);
  assign servicing = (state == entering);
  assign ctx = (state == run_int);

  // A stall retires the held instruction even though halt is still high.
  assign accept = instr_valid && !servicing && (!halt || stall);

  // a mul dropped by a stall never reaches the pipeline.
  assign mul_start = accept && !halt && (kind == k_mul);

  // ==============================
  // context state machine
  // ==============================

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= run_main;
    end else begin
      case (state)
        run_main: begin
          if (irq && !halt) begin  // wait for a halted instruction to clear first.
            state <= entering;
          end
        end
        entering: state <= run_int;
        run_int: begin
          if (accept && kind == k_rti) begin
            state <= run_main;
          end
        end
        default: state <= run_main;
      endcase
    end
  end

  // retired count covers main-context instructions only.
  always_ff @(posedge clk) begin
    if (reset) begin
      ret_count <= '0;
      out_valid <= 1'b0;
    end else begin
      if (accept && !ctx) begin
        ret_count <= ret_count + 1'b1;
      end
      out_valid <= accept && (kind == k_cvz);
    end
  end

endmodule

`default_nettype wire

// File: design/mul_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module mul_pipe import conveyor_pkg::*; #(
  parameter int MUL_LATENCY = 3
) (
  input  wire        clk,
  input  wire        reset,
  input  wire        start,
  input  wire        ctx,
  input  wire addr_t dest_addr,
  input  wire slot_t operand_a,
  input  wire slot_t operand_b,
  output slot_wr_t   result
);

  typedef struct packed {
    logic                    ctx;
    addr_t                   addr;
    fault_t                  fault;    // operand fault carried along.
    logic [2*word_width-1:0] product;
  } stage_t;

  logic [MUL_LATENCY-1:0] valid;
  stage_t stage [MUL_LATENCY];
  logic [2*word_width-1:0] product;
  fault_t op_fault;
  logic overflow;

  assign product = operand_a.value * operand_b.value;
  assign op_fault = (operand_a.fault != f_none) ? operand_a.fault : operand_b.fault;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
    end else begin
      valid[0] <= start;
      for (int i = 1; i < MUL_LATENCY; i++) begin
        valid[i] <= valid[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    stage[0] <= '{ctx: ctx, addr: dest_addr, fault: op_fault, product: product};
    for (int i = 1; i < MUL_LATENCY; i++) begin
      stage[i] <= stage[i-1];
    end
  end

  // the last stage drives the write port, so the slot fills MUL_LATENCY edges after start.
  assign overflow = |stage[MUL_LATENCY-1].product[2*word_width-1:word_width];

  always_comb begin
    result.en = valid[MUL_LATENCY-1];
    result.ctx = stage[MUL_LATENCY-1].ctx;
    result.addr = stage[MUL_LATENCY-1].addr;
    result.data.finished = 1'b1;
    result.data.fault = overflow ? f_overflow : stage[MUL_LATENCY-1].fault;
    result.data.value = stage[MUL_LATENCY-1].product[word_width-1:0];
  end

endmodule

`default_nettype wire

// File: design/stall_timer.sv
`timescale 1ns/100ps
`default_nettype none

module stall_timer #(
  parameter int STALL_LIMIT = 12
) (
  input  wire  clk,
  input  wire  reset,
  input  wire  halt,
  output logic stall
);

  localparam int COUNT_WIDTH = $clog2(STALL_LIMIT + 1);

  // number of halted cycles already seen before the current one.
  logic [COUNT_WIDTH-1:0] count;

  // the pulse lands in the STALL_LIMIT-th consecutive halted cycle.
  assign stall = halt && (count == COUNT_WIDTH'(STALL_LIMIT - 1));

  always_ff @(posedge clk) begin
    if (reset || !halt || stall) begin
      count <= '0;  // restart after a pulse too, so a held halt pulses again.
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: tests/conveyor_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module conveyor_core_tb import conveyor_pkg::*;;

  localparam int ADDR_W = 4;
  localparam int MUL_LAT = 3;
  localparam int STALL_LIM = 12;
  localparam int c_nop = 0, c_psh = 1, c_mul = 2, c_cvz = 3, c_rti = 4;

  typedef struct packed {
    logic       irq;
    word_t      bus;
    logic [7:0] ins;
  } entry_t;

  logic clk;
  logic reset;
  instr_u instr;
  logic instr_valid;
  logic irq;
  word_t irq_bus;
  logic halt;
  logic out_valid;
  word_t out_value;
  fault_t out_fault;
  logic int_active;
  logic stall;

  // reference model of both conveyors; it holds the state after the coming edge.
  slot_t m_conv [2][1 << ADDR_W];
  logic [ADDR_W-1:0] m_head [2];
  int m_state;                   // 0 main, 1 entering, 2 handler.
  word_t m_ret;
  int m_cnt;
  logic m_accepted;
  logic exp_ov;
  word_t exp_val;
  fault_t exp_fault;
  int cyc;
  slot_wr_t pend_w [$];
  int pend_due [$];

  entry_t prog_q [$];
  logic [31:0] lfsr_state = 32'hd383;
  int n_cvz = 0;
  int n_checks = 0;
  int n_errors = 0;
  int limit = 1000000;
  int cycles = 0;
  logic stim_done = 1'b0;

  conveyor_core #(
    .CONVEYOR_ADDR_WIDTH (ADDR_W),
    .MUL_LATENCY         (MUL_LAT),
    .STALL_LIMIT         (STALL_LIM)
  ) UUT (
    .clk         (clk),
    .reset       (reset),
    .instr       (instr),
    .instr_valid (instr_valid),
    .irq         (irq),
    .irq_bus     (irq_bus),
    .halt        (halt),
    .out_valid   (out_valid),
    .out_value   (out_value),
    .out_fault   (out_fault),
    .int_active  (int_active),
    .stall       (stall)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // ==============================
  // stimulus helpers
  // ==============================

  // galois lfsr, one step for every bit handed out.
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] val;
    logic bit_out;
    val = '0;
    for (int i = 0; i < n; i++) begin
      bit_out = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (bit_out) lfsr_state = lfsr_state ^ 32'h8020_0003;
      val = (val << 1) | 32'(bit_out);
    end
    return val;
  endfunction

  function automatic int instr_class(logic [7:0] ins);
    if (ins[7:6] == op_psh) return c_psh;
    case (ins[7:4])
      op_mul:  return c_mul;
      op_cvz:  return c_cvz;
      op_rti:  return c_rti;
      default: return c_nop;   // unused patterns act as nop.
    endcase
  endfunction

  task automatic add_entry(logic [7:0] ins, logic with_irq = 1'b0, word_t bus = '0);
    prog_q.push_back('{irq: with_irq, bus: bus, ins: ins});
    if (instr_class(ins) == c_cvz) n_cvz++;
  endtask

  task automatic add_psh(logic [5:0] imm);
    add_entry({op_psh, imm});
  endtask

  task automatic add_op(logic [3:0] op, logic [3:0] off);
    add_entry({op, off});
  endtask

  // ==============================
  // model and checks
  // ==============================

  task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic reset_model();
    for (int c = 0; c < 2; c++) begin
      m_head[c] = '0;
      for (int s = 0; s < (1 << ADDR_W); s++) m_conv[c][s] = '0;
    end
    m_state = 0;
    m_ret = '0;
    m_cnt = 0;
    m_accepted = 1'b0;
    exp_ov = 1'b0;
    cyc = 0;
    pend_w.delete();
    pend_due.delete();
  endtask

  task automatic step_model();
    int kind;
    logic ctx_now, serv, exp_halt, exp_stall, acc;
    logic [ADDR_W-1:0] a_addr, b_addr, dst, h0;
    slot_t a, b;
    logic [31:0] prod;
    slot_wr_t due_w, new_w;
    kind = instr_class(instr);
    serv = (m_state == 1);
    ctx_now = (m_state == 2);
    a_addr = m_head[ctx_now] + instr.off.offset;
    b_addr = a_addr + 1'b1;
    dst = m_head[ctx_now] - 1'b1;    // results land just behind the head.
    a = m_conv[ctx_now][a_addr];
    b = m_conv[ctx_now][b_addr];
    exp_halt = (kind == c_cvz) ? !a.finished :
               (kind == c_mul) ? !(a.finished && b.finished) : 1'b0;
    exp_stall = exp_halt && (m_cnt == STALL_LIM - 1);
    acc = instr_valid && !serv && (!exp_halt || exp_stall);

    check_value("halt", halt, exp_halt);
    check_value("stall", stall, exp_stall);
    check_value("int_active", int_active, ctx_now);
    check_value("out_valid", out_valid, exp_ov);
    if (exp_ov) begin
      check_value("out_value", out_value, exp_val);
      check_value("out_fault", out_fault, exp_fault);
    end

    if (pend_due.size() > 0 && pend_due[0] == cyc) begin
      due_w = pend_w.pop_front();
      void'(pend_due.pop_front());
      m_conv[due_w.ctx][due_w.addr] = due_w.data;
    end
    if (serv) begin
      h0 = m_head[0];
      m_conv[0][h0 - 1'b1] = '{finished: 1'b1, fault: f_none, value: m_ret};
      m_conv[0][h0 - 2'd2] = '{finished: 1'b1, fault: f_none, value: irq_bus};
      m_head[0] = h0 - 2'd2;
      m_head[1] = '0;
    end else if (acc && !exp_halt && kind == c_psh) begin
      m_conv[ctx_now][dst] = '{finished: 1'b1, fault: f_none, value: word_t'(instr.imm.value)};
      m_head[ctx_now] = dst;
    end else if (acc && !exp_halt && kind == c_mul) begin
      prod = a.value * b.value;
      new_w.en = 1'b1;
      new_w.ctx = ctx_now;
      new_w.addr = dst;
      new_w.data.finished = 1'b1;
      new_w.data.value = prod[15:0];
      if (prod[31:16] != 0) new_w.data.fault = f_overflow;
      else if (a.fault != f_none) new_w.data.fault = a.fault;
      else new_w.data.fault = b.fault;
      pend_w.push_back(new_w);
      pend_due.push_back(cyc + MUL_LAT);
      m_conv[ctx_now][dst] = '0;     // reserved slot, unfinished until the product lands.
      m_head[ctx_now] = dst;
    end

    exp_ov = acc && (kind == c_cvz);
    if (exp_ov) begin
      exp_val = a.value;
      exp_fault = exp_halt ? f_stall : a.fault;
    end
    if (acc && !ctx_now) m_ret = m_ret + 1'b1;
    if (m_state == 0 && irq && !exp_halt) m_state = 1;
    else if (m_state == 1) m_state = 2;
    else if (m_state == 2 && acc && kind == c_rti) m_state = 0;
    m_cnt = (!exp_halt || exp_stall) ? 0 : m_cnt + 1;
    m_accepted = acc;
    cyc++;
  endtask

  // the model stays cleared until reset is known to be low.
  always @(negedge clk) begin
    if (reset !== 1'b0) reset_model();
    else step_model();
  end

  // a held instruction moves on only once the model says it was taken.
  task automatic drive_next();
    entry_t e;
    if (irq && m_state != 0) irq <= 1'b0;
    if (!instr_valid || m_accepted) begin
      if (prog_q.size() > 0) begin
        e = prog_q.pop_front();
        instr <= e.ins;
        instr_valid <= 1'b1;
        if (e.irq) begin
          irq <= 1'b1;
          irq_bus <= e.bus;
        end
      end else begin
        instr <= '0;
        instr_valid <= 1'b0;
        stim_done = 1'b1;
      end
    end
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("Test FAILED");
      $finish;
    end
  end

  // ==============================
  // test sequence
  // ==============================

  initial begin
    int k;
    reset = 1'b1;
    instr = '0;
    instr_valid = 1'b0;
    irq = 1'b0;
    irq_bus = '0;

    add_op(op_cvz, 4'd5);                  // never-written slot, runs into the stall timer.
    add_psh(6'd1);
    add_op(op_cvz, 4'd0);
    add_psh(6'd5);
    add_op(op_cvz, 4'd0);
    add_psh(6'd7);
    add_psh(6'd9);
    add_op(op_mul, 4'd0);
    add_op(op_cvz, 4'd0);                  // waits on the product.
    add_psh(6'd63);
    add_psh(6'd63);
    add_op(op_mul, 4'd0);
    add_psh(6'd63);
    add_op(op_mul, 4'd0);                  // 3969 times 63 overflows the word.
    add_op(op_cvz, 4'd0);
    for (int i = 3; i <= 6; i++) add_psh(6'(i));
    repeat (3) add_op(op_mul, 4'd2);       // three products in flight together.
    for (int i = 0; i < 3; i++) add_op(op_cvz, 4'(i));
    add_entry({op_nop, 4'd0}, 1'b1, 16'hbeef);
    add_psh(6'd33);
    add_psh(6'd44);
    add_op(op_cvz, 4'd0);
    add_op(op_rti, 4'd0);
    add_op(op_cvz, 4'd0);
    add_op(op_cvz, 4'd1);

    for (int i = 0; i < 400; i++) begin
      k = take_bits(5);
      if (k < 2) add_op(op_nop, 4'd0);
      else if (k < 12) add_psh(take_bits(6));
      else if (k < 20) add_op(op_mul, take_bits(2));
      else if (k < 28) add_op(op_cvz, take_bits(3));
      else if (k < 30) add_op(op_rti, 4'd0);
      else if (k == 30) add_op(op_nop, 4'd0);
      else add_entry({op_nop, 4'd0}, 1'b1, take_bits(16));
    end
    limit = 4 * prog_q.size() + STALL_LIM * n_cvz;

    repeat (3) @(posedge clk);
    reset <= 1'b0;
    while (!stim_done) begin
      @(posedge clk);
      drive_next();
    end
    repeat (MUL_LAT + 4) @(posedge clk);

    $display("checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
